/* verilog/periph_pkg.sv */
// Address map, register indices, widths and error constants of the peripheral subsystem
`default_nettype none

package periph_pkg;

    // --------------------
    // Bus
    // --------------------
    localparam int AddrWidth = 32;
    localparam int DataWidth = 32;

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;

    // Slot field sits above the 4 KiB register window
    localparam int SlotLsb   = 12;
    localparam int SlotWidth = 4;

    typedef logic [SlotWidth-1:0] slot_t;

    localparam slot_t SlotIrq  = 4'd0;
    localparam slot_t SlotUart = 4'd1; // Not fitted
    localparam slot_t SlotSpi  = 4'd2; // Not fitted
    localparam slot_t SlotEth  = 4'd3; // Not fitted
    localparam slot_t SlotGpio = 4'd4;

    localparam int RegIdxWidth = 3; // Word index, addr[4:2]

    typedef logic [RegIdxWidth-1:0] reg_idx_t;

    localparam data_t ErrData = 32'hdeadbeef;

    // --------------------
    // Interrupts
    // --------------------
    localparam int NumTargets = 2;
    localparam int NumSources = 4;
    localparam int IdWidth    = 3;
    localparam int NumExtIrq  = 3;

    typedef logic [IdWidth-1:0]    irq_id_t;  // 0 means no interrupt
    typedef logic [NumSources-1:0] src_vec_t; // Bit n is source ID n+1

    localparam reg_idx_t IrqRegPending = 3'd0;
    localparam reg_idx_t IrqRegEnable0 = 3'd1;
    localparam reg_idx_t IrqRegEnable1 = 3'd2;
    localparam reg_idx_t IrqRegClaim0  = 3'd3;
    localparam reg_idx_t IrqRegClaim1  = 3'd4;

    // --------------------
    // GPIO
    // --------------------
    localparam int GpioWidth = 8;

    typedef logic [GpioWidth-1:0] gpio_t;

    localparam reg_idx_t GpioRegLed   = 3'd0;
    localparam reg_idx_t GpioRegDip   = 3'd1; // Read only
    localparam reg_idx_t GpioRegIrqEn = 3'd2;

endpackage

`default_nettype wire

/* verilog/input_sync.sv */
// Two-flop synchronizer for asynchronous level inputs, payload type as parameter
`default_nettype none

module input_sync #(
    parameter type sync_t = logic
) (
    input  logic  clk_i    , // Clock
    input  logic  arst_n_i , // Asynchronous reset active low
    input  sync_t async_i  ,
    output sync_t sync_o
);

    sync_t meta_q; // First stage, may go metastable
    sync_t sync_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;
        end
    end

    assign sync_o = sync_q;

endmodule

`default_nettype wire

/* verilog/periph_bus_ctrl.sv */
// Register bus decoder with block strobes, absent-slot error and registered response
`default_nettype none

module periph_bus_ctrl
    import periph_pkg::*;
(
    input  logic     clk_i        , // Clock
    input  logic     arst_n_i     , // Asynchronous reset active low
    // Bus master side
    input  logic     req_i        ,
    input  logic     we_i         ,
    input  addr_t    addr_i       ,
    input  data_t    wdata_i      ,
    output logic     rvalid_o     ,
    output data_t    rdata_o      ,
    output logic     err_o        ,
    // Peripheral blocks
    output logic     irq_sel_o    ,
    output logic     gpio_sel_o   ,
    output logic     we_o         ,
    output reg_idx_t idx_o        ,
    output data_t    wdata_o      ,
    input  data_t    irq_rdata_i  ,
    input  data_t    gpio_rdata_i
);

    slot_t slot;
    logic  absent;
    data_t rdata_d;

    logic  rvalid_q;
    logic  err_q;
    data_t rdata_q;

    // --------------------
    // Decode
    // --------------------
    assign slot  = addr_i[SlotLsb +: SlotWidth];
    assign idx_o = addr_i[2 +: RegIdxWidth];

    assign we_o    = we_i;
    assign wdata_o = wdata_i;

    always_comb begin
        irq_sel_o  = 1'b0;
        gpio_sel_o = 1'b0;
        absent     = 1'b0;
        if (req_i) begin
            case (slot)
                SlotIrq:  irq_sel_o  = 1'b1;
                SlotGpio: gpio_sel_o = 1'b1;
                default:  absent     = 1'b1; // UART, SPI, Ethernet and holes
            endcase
        end
    end

    // --------------------
    // Response
    // --------------------
    always_comb begin
        rdata_d = '0;
        if (absent) begin
            rdata_d = ErrData;
        end else if (!we_i) begin
            if (irq_sel_o) begin
                rdata_d = irq_rdata_i;
            end else if (gpio_sel_o) begin
                rdata_d = gpio_rdata_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
            err_q    <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= req_i;
            err_q    <= absent;
            rdata_q  <= rdata_d;
        end
    end

    assign rvalid_o = rvalid_q;
    assign err_o    = err_q;
    assign rdata_o  = rdata_q;

    // Every request gets exactly one response, one cycle later
    a_rvalid_follows_req : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rvalid_o == $past(req_i)
    );

endmodule

`default_nettype wire

/* verilog/gpio_regs.sv */
// GPIO registers with LED output, switch readback and switch-change interrupt
`default_nettype none

module gpio_regs
    import periph_pkg::*;
(
    input  logic     clk_i        , // Clock
    input  logic     arst_n_i     , // Asynchronous reset active low
    input  logic     sel_i        ,
    input  logic     we_i         ,
    input  reg_idx_t idx_i        ,
    input  data_t    wdata_i      ,
    output data_t    rdata_o      ,
    input  gpio_t    dip_i        , // Already synchronized
    output gpio_t    leds_o       ,
    output logic     change_irq_o
);

    gpio_t led_q;
    gpio_t dip_prev_q;
    logic  irq_en_q;

    // --------------------
    // Registers
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            led_q      <= '0;
            irq_en_q   <= 1'b0;
            dip_prev_q <= '0;
        end else begin
            dip_prev_q <= dip_i;
            if (sel_i && we_i) begin
                case (idx_i)
                    GpioRegLed:   led_q    <= wdata_i[GpioWidth-1:0];
                    GpioRegIrqEn: irq_en_q <= wdata_i[0];
                    default: ; // DIP is read only
                endcase
            end
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        case (idx_i)
            GpioRegLed:   rdata_o[GpioWidth-1:0] = led_q;
            GpioRegDip:   rdata_o[GpioWidth-1:0] = dip_i;
            GpioRegIrqEn: rdata_o[0]             = irq_en_q;
            default: ;
        endcase
    end

    assign leds_o = led_q;

    // One-cycle pulse, the previous value catches up next edge
    assign change_irq_o = irq_en_q && (dip_i != dip_prev_q);

endmodule

`default_nettype wire

/* verilog/irq_ctrl.sv */
// Interrupt controller with edge gateway, pending bits, per-target enables and claim
`default_nettype none

module irq_ctrl
    import periph_pkg::*;
(
    input  logic                  clk_i    , // Clock
    input  logic                  arst_n_i , // Asynchronous reset active low
    input  logic                  sel_i    ,
    input  logic                  we_i     ,
    input  reg_idx_t              idx_i    ,
    input  data_t                 wdata_i  ,
    output data_t                 rdata_o  ,
    input  src_vec_t              src_i    ,
    output logic [NumTargets-1:0] irq_o
);

    src_vec_t                  src_q;
    src_vec_t                  edge_set;
    src_vec_t                  pending_q;
    src_vec_t                  claim_clr;
    src_vec_t [NumTargets-1:0] enable_q;
    src_vec_t [NumTargets-1:0] masked;
    src_vec_t [NumTargets-1:0] claim_oh;
    irq_id_t  [NumTargets-1:0] claim_id;
    logic     [NumTargets-1:0] claim_rd;

    function automatic irq_id_t oh_to_id(src_vec_t oh);
        irq_id_t id;
        id = '0;
        for (int i = 0; i < NumSources; i++) begin
            if (oh[i]) begin
                id = irq_id_t'(i + 1);
            end
        end
        return id;
    endfunction

    // --------------------
    // Gateway
    // --------------------
    assign edge_set = src_i & ~src_q;

    // --------------------
    // Per target claim
    // --------------------
    for (genvar t = 0; t < NumTargets; t++) begin : gen_target
        assign masked[t]   = pending_q & enable_q[t];
        assign claim_oh[t] = masked[t] & (~masked[t] + 1'b1); // Lowest ID wins
        assign claim_id[t] = oh_to_id(claim_oh[t]);
        assign claim_rd[t] = sel_i && !we_i && (idx_i == reg_idx_t'(IrqRegClaim0 + t));
        assign irq_o[t]    = |masked[t];

        a_claim_valid : assert property (
            @(posedge clk_i) disable iff (!arst_n_i)
            (claim_id[t] != '0) |->
                |(pending_q & enable_q[t] & (src_vec_t'(1) << (claim_id[t] - 1'b1)))
        );
    end

    always_comb begin
        claim_clr = '0;
        for (int t = 0; t < NumTargets; t++) begin
            if (claim_rd[t]) begin
                claim_clr = claim_clr | claim_oh[t];
            end
        end
    end

    // --------------------
    // State
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q     <= '0;
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            src_q     <= src_i;
            pending_q <= (pending_q & ~claim_clr) | edge_set; // New edge beats the clear
            if (sel_i && we_i) begin
                case (idx_i)
                    IrqRegEnable0: enable_q[0] <= wdata_i[NumSources-1:0];
                    IrqRegEnable1: enable_q[1] <= wdata_i[NumSources-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        case (idx_i)
            IrqRegPending: rdata_o[NumSources-1:0] = pending_q;
            IrqRegEnable0: rdata_o[NumSources-1:0] = enable_q[0];
            IrqRegEnable1: rdata_o[NumSources-1:0] = enable_q[1];
            IrqRegClaim0:  rdata_o[IdWidth-1:0]    = claim_id[0];
            IrqRegClaim1:  rdata_o[IdWidth-1:0]    = claim_id[1];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/periph_top.sv */
// Peripheral subsystem top with synchronizers, bus controller, GPIO and interrupt blocks
`default_nettype none

module periph_top
    import periph_pkg::*;
(
    input  logic                  clk_i          , // Clock
    input  logic                  arst_n_i       , // Asynchronous reset active low
    // Register bus
    input  logic                  req_i          ,
    input  logic                  we_i           ,
    input  addr_t                 addr_i         ,
    input  data_t                 wdata_i        ,
    output logic                  rvalid_o       ,
    output data_t                 rdata_o        ,
    output logic                  err_o          ,
    // Board I/O
    input  gpio_t                 dip_switches_i ,
    output gpio_t                 leds_o         ,
    input  logic [NumExtIrq-1:0]  irq_src_i      ,
    output logic [NumTargets-1:0] irq_o
);

    gpio_t                dip_sync;
    logic [NumExtIrq-1:0] ext_irq_sync;

    logic     irq_sel;
    logic     gpio_sel;
    logic     blk_we;
    reg_idx_t blk_idx;
    data_t    blk_wdata;
    data_t    irq_rdata;
    data_t    gpio_rdata;
    logic     gpio_change_irq;

    // --------------------
    // Synchronizers
    // --------------------
    input_sync #(
        .sync_t ( gpio_t )
    ) i_sync_dip (
        .clk_i    ( clk_i          ),
        .arst_n_i ( arst_n_i       ),
        .async_i  ( dip_switches_i ),
        .sync_o   ( dip_sync       )
    );

    input_sync #(
        .sync_t ( logic [NumExtIrq-1:0] )
    ) i_sync_irq (
        .clk_i    ( clk_i        ),
        .arst_n_i ( arst_n_i     ),
        .async_i  ( irq_src_i    ),
        .sync_o   ( ext_irq_sync )
    );

    // --------------------
    // Bus and blocks
    // --------------------
    periph_bus_ctrl i_bus_ctrl (
        .clk_i        ( clk_i      ),
        .arst_n_i     ( arst_n_i   ),
        .req_i        ( req_i      ),
        .we_i         ( we_i       ),
        .addr_i       ( addr_i     ),
        .wdata_i      ( wdata_i    ),
        .rvalid_o     ( rvalid_o   ),
        .rdata_o      ( rdata_o    ),
        .err_o        ( err_o      ),
        .irq_sel_o    ( irq_sel    ),
        .gpio_sel_o   ( gpio_sel   ),
        .we_o         ( blk_we     ),
        .idx_o        ( blk_idx    ),
        .wdata_o      ( blk_wdata  ),
        .irq_rdata_i  ( irq_rdata  ),
        .gpio_rdata_i ( gpio_rdata )
    );

    gpio_regs i_gpio (
        .clk_i        ( clk_i           ),
        .arst_n_i     ( arst_n_i        ),
        .sel_i        ( gpio_sel        ),
        .we_i         ( blk_we          ),
        .idx_i        ( blk_idx         ),
        .wdata_i      ( blk_wdata       ),
        .rdata_o      ( gpio_rdata      ),
        .dip_i        ( dip_sync        ),
        .leds_o       ( leds_o          ),
        .change_irq_o ( gpio_change_irq )
    );

    irq_ctrl i_irq (
        .clk_i    ( clk_i                           ),
        .arst_n_i ( arst_n_i                        ),
        .sel_i    ( irq_sel                         ),
        .we_i     ( blk_we                          ),
        .idx_i    ( blk_idx                         ),
        .wdata_i  ( blk_wdata                       ),
        .rdata_o  ( irq_rdata                       ),
        .src_i    ( {ext_irq_sync, gpio_change_irq} ), // GPIO change is ID 1
        .irq_o    ( irq_o                           )
    );

endmodule

`default_nettype wire

/* testbench/tb_periph_top.sv */
// Random-stimulus testbench with reference model for the peripheral subsystem
`default_nettype none

module tb_periph_top
    import periph_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ResetCycles  = 16;
    localparam int SettleCycles = 6;
    localparam int IrqTimeout   = 50;

    logic                  clk;
    logic                  arst_n;
    logic                  req;
    logic                  we;
    addr_t                 addr;
    data_t                 wdata;
    logic                  rvalid;
    data_t                 rdata;
    logic                  err;
    gpio_t                 dip_switches;
    gpio_t                 leds;
    logic [NumExtIrq-1:0]  irq_src;
    logic [NumTargets-1:0] irq;

    // Reference model state
    gpio_t                m_led;
    logic                 m_gpio_en;
    src_vec_t             m_en [NumTargets];
    src_vec_t             m_pend;
    gpio_t                m_dip;
    logic [NumExtIrq-1:0] m_src;

    logic  exp_valid; // Response due at the next falling edge
    data_t exp_rdata;
    logic  exp_err;

    int checks;
    int errors;
    int checks0;
    int errors0;

    periph_top UUT (
        .clk_i          ( clk          ),
        .arst_n_i       ( arst_n       ),
        .req_i          ( req          ),
        .we_i           ( we           ),
        .addr_i         ( addr         ),
        .wdata_i        ( wdata        ),
        .rvalid_o       ( rvalid       ),
        .rdata_o        ( rdata        ),
        .err_o          ( err          ),
        .dip_switches_i ( dip_switches ),
        .leds_o         ( leds         ),
        .irq_src_i      ( irq_src      ),
        .irq_o          ( irq          )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------
    // Model
    // --------------------
    function automatic irq_id_t lowest_id(src_vec_t v);
        irq_id_t id;
        id = '0;
        for (int i = NumSources - 1; i >= 0; i--) begin
            if (v[i]) begin
                id = irq_id_t'(i + 1);
            end
        end
        return id;
    endfunction

    function automatic logic [NumTargets-1:0] model_irq();
        logic [NumTargets-1:0] v;
        for (int t = 0; t < NumTargets; t++) begin
            v[t] = |(m_pend & m_en[t]);
        end
        return v;
    endfunction

    function automatic addr_t make_addr(slot_t s, reg_idx_t idx);
        addr_t a;
        a = $urandom(); // Junk in the undecoded bits
        a[SlotLsb +: SlotWidth] = s;
        a[2 +: RegIdxWidth]     = idx;
        return a;
    endfunction

    task automatic take_claim(input int t);
        irq_id_t id;
        id = lowest_id(m_pend & m_en[t]);
        exp_rdata = data_t'(id);
        if (id != '0) begin
            m_pend[id - 1] = 1'b0;
        end
    endtask

    task automatic predict(input logic w, input addr_t a, input data_t wd);
        slot_t    s;
        reg_idx_t idx;
        s         = a[SlotLsb +: SlotWidth];
        idx       = a[2 +: RegIdxWidth];
        exp_valid = 1'b1;
        exp_rdata = '0;
        exp_err   = 1'b0;
        if (s == SlotGpio) begin
            if (w && idx == GpioRegLed) begin
                m_led = wd[GpioWidth-1:0];
            end else if (w && idx == GpioRegIrqEn) begin
                m_gpio_en = wd[0];
            end else if (!w) begin
                case (idx)
                    GpioRegLed:   exp_rdata = data_t'(m_led);
                    GpioRegDip:   exp_rdata = data_t'(m_dip);
                    GpioRegIrqEn: exp_rdata = data_t'(m_gpio_en);
                    default: ;
                endcase
            end
        end else if (s == SlotIrq) begin
            if (w && idx == IrqRegEnable0) begin
                m_en[0] = wd[NumSources-1:0];
            end else if (w && idx == IrqRegEnable1) begin
                m_en[1] = wd[NumSources-1:0];
            end else if (!w) begin
                case (idx)
                    IrqRegPending: exp_rdata = data_t'(m_pend);
                    IrqRegEnable0: exp_rdata = data_t'(m_en[0]);
                    IrqRegEnable1: exp_rdata = data_t'(m_en[1]);
                    IrqRegClaim0:  take_claim(0);
                    IrqRegClaim1:  take_claim(1);
                    default: ;
                endcase
            end
        end else begin
            exp_rdata = ErrData; // Absent slot
            exp_err   = 1'b1;
        end
    endtask

    // --------------------
    // Checks and bus
    // --------------------
    task automatic check_value(input string name, input data_t expv, input data_t act);
        checks++;
        if (act !== expv) begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, expv, act);
        end
    endtask

    task automatic check_response();
        check_value("rvalid_o", data_t'(exp_valid), data_t'(rvalid));
        check_value("err_o", data_t'(exp_err), data_t'(err));
        if (exp_valid) begin
            check_value("rdata_o", exp_rdata, rdata);
        end
        check_value("leds_o", data_t'(m_led), data_t'(leds));
        check_value("irq_o", data_t'(model_irq()), data_t'(irq));
    endtask

    // One bus cycle, checks the previous response first
    task automatic step(input logic r, input logic w, input addr_t a, input data_t wd);
        @(negedge clk);
        check_response();
        req   = r;
        we    = w;
        addr  = a;
        wdata = wd;
        if (r) begin
            predict(w, a, wd);
        end else begin
            exp_valid = 1'b0;
            exp_err   = 1'b0;
        end
    endtask

    task automatic idle();
        step(1'b0, 1'b0, '0, '0);
    endtask

    task automatic access(input slot_t s, input reg_idx_t idx, input logic w, input data_t wd);
        step(1'b1, w, make_addr(s, idx), wd);
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (irq !== model_irq() && n < IrqTimeout) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (irq !== model_irq()) begin
            errors++;
            $display("Timeout at %0t ns: irq_o stuck at %b, model has %b",
                     $time, irq, model_irq());
        end
    endtask

    // Switches and sources only move while the bus is idle
    task automatic apply_inputs(input gpio_t d, input logic [NumExtIrq-1:0] s);
        idle();
        dip_switches = d;
        irq_src      = s;
        m_pend       = m_pend | {s & ~m_src, 1'b0};
        if (m_gpio_en && d != m_dip) begin
            m_pend[0] = 1'b1;
        end
        m_dip = d;
        m_src = s;
        repeat (SettleCycles) @(negedge clk);
        wait_irq();
    endtask

    task automatic read_all();
        for (int i = 0; i <= int'(IrqRegClaim1); i++) begin
            access(SlotIrq, reg_idx_t'(i), 1'b0, $urandom());
        end
        for (int i = 0; i <= int'(GpioRegIrqEn); i++) begin
            access(SlotGpio, reg_idx_t'(i), 1'b0, $urandom());
        end
    endtask

    task automatic end_test(input string name);
        idle();
        $display("%s done: %0d checks, %0d errors", name, checks - checks0, errors - errors0);
        checks0 = checks;
        errors0 = errors;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic after_reset();
        check_response();
        read_all();
        end_test("after_reset");
    endtask

    task automatic led_enable_rw();
        slot_t s;
        for (int i = 0; i < 300; i++) begin
            s = ($urandom_range(0, 1) != 0) ? SlotGpio : SlotIrq;
            step($urandom_range(0, 9) != 0, $urandom_range(0, 1) != 0,
                 make_addr(s, reg_idx_t'($urandom_range(0, 7))), $urandom());
        end
        end_test("led_enable_rw");
    endtask

    task automatic absent_slots();
        slot_t s;
        for (int i = 0; i < 100; i++) begin
            s = slot_t'($urandom_range(1, 14));
            if (s >= SlotGpio) begin
                s = s + 1'b1; // Skip the GPIO slot
            end
            access(s, reg_idx_t'($urandom_range(0, 7)), $urandom_range(0, 1) != 0, $urandom());
        end
        read_all(); // State must be untouched
        end_test("absent_slots");
    endtask

    task automatic dip_change();
        gpio_t d;
        access(SlotGpio, GpioRegIrqEn, 1'b1, 32'h1);
        access(SlotIrq, IrqRegEnable0, 1'b1, 32'h1);
        access(SlotIrq, IrqRegEnable1, 1'b1, 32'h0);
        for (int i = 0; i < 9; i++) begin
            if (i == 8) begin
                access(SlotGpio, GpioRegIrqEn, 1'b1, 32'h0); // Last change must stay quiet
            end
            d = gpio_t'($urandom());
            if (d == m_dip) begin
                d = ~d;
            end
            apply_inputs(d, m_src);
            access(SlotGpio, GpioRegDip, 1'b0, '0);
            access(SlotIrq, IrqRegPending, 1'b0, '0);
            access(SlotIrq, IrqRegClaim0, 1'b0, '0);
            access(SlotIrq, IrqRegClaim0, 1'b0, '0);
        end
        end_test("dip_change");
    endtask

    task automatic ext_irq_claims();
        for (int i = 0; i < 16; i++) begin
            if (i % 4 == 0) begin
                access(SlotIrq, IrqRegEnable0, 1'b1, $urandom());
                access(SlotIrq, IrqRegEnable1, 1'b1, (i == 12) ? 32'hf : $urandom());
            end
            apply_inputs(m_dip, NumExtIrq'($urandom()));
            access(SlotIrq, IrqRegPending, 1'b0, '0);
            for (int t = 0; t < NumTargets; t++) begin
                for (int n = 0; n < NumSources && (m_pend & m_en[t]) != '0; n++) begin
                    access(SlotIrq, reg_idx_t'(int'(IrqRegClaim0) + t), 1'b0, '0);
                end
                access(SlotIrq, reg_idx_t'(int'(IrqRegClaim0) + t), 1'b0, '0); // Now empty
            end
        end
        end_test("ext_irq_claims");
    endtask

    initial begin
        void'($urandom(32'hde4c6e1f));
        arst_n       = 1'b0;
        req          = 1'b0;
        we           = 1'b0;
        addr         = '0;
        wdata        = '0;
        irq_src      = '0;
        dip_switches = gpio_t'($urandom());
        m_led        = '0;
        m_gpio_en    = 1'b0;
        m_en[0]      = '0;
        m_en[1]      = '0;
        m_pend       = '0;
        m_dip        = dip_switches;
        m_src        = '0;
        exp_valid    = 1'b0;
        exp_rdata    = '0;
        exp_err      = 1'b0;
        checks       = 0;
        errors       = 0;
        checks0      = 0;
        errors0      = 0;
        repeat (ResetCycles) @(negedge clk);
        arst_n = 1'b1;
        repeat (SettleCycles) @(negedge clk); // Switches through the synchronizer

        after_reset();
        led_enable_rw();
        absent_slots();
        dip_change();
        ext_irq_claims();

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/periph_pkg.sv
verilog/input_sync.sv
verilog/periph_bus_ctrl.sv
verilog/gpio_regs.sv
verilog/irq_ctrl.sv
verilog/periph_top.sv
testbench/tb_periph_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_periph_top -f flist.f -o sim_periph
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_periph > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
